//--- source/kyber_pkg.sv
`default_nettype none

////////////////////////////////////////
// Kyber field constants
////////////////////////////////////////

package kyber_pkg;

  // Prime modulus of the coefficient ring
  localparam int KYBER_Q = 3329;

  // Bits needed for one reduced coefficient
  // 2^12 is the smallest power of two above q
  localparam int Q_BITS = 12;

  // Storage width of one coefficient share
  localparam int COEF_W = 16;

  // Decode rounding offset
  // Rounded-up quarter of q, 833
  // Shifts the "one" window so it starts at zero
  localparam int Q_QUARTER = (KYBER_Q + 3) / 4;

endpackage

`default_nettype wire

//--- source/mask_pkg.sv
`default_nettype none

////////////////////////////////////////
// Masking and pipeline constants
////////////////////////////////////////

package mask_pkg;

  // Width of the fresh random word per coefficient
  localparam int RAND_W = 16;

  // Stage latencies in cycles
  localparam int OFFSET_LAT  = 1;
  localparam int RESCALE_LAT = 2;
  localparam int A2B_LAT     = 3;

  // End to end, plus the output bit register
  localparam int DECODE_LAT = OFFSET_LAT + RESCALE_LAT + A2B_LAT + 1;

endpackage

`default_nettype wire

//--- source/quarter_offset_sub.sv
`timescale 1ns/1ps
`default_nettype none

module quarter_offset_sub (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        ce,
  input  logic [kyber_pkg::COEF_W-1:0] c1,
  input  logic [kyber_pkg::COEF_W-1:0] c2,
  output logic                        data_valid,
  output logic [kyber_pkg::COEF_W-1:0] y1,
  output logic [kyber_pkg::COEF_W-1:0] y2
);

  import kyber_pkg::*;
  import mask_pkg::*;

  // Subtrahend and its wrap-around complement
  localparam logic [COEF_W-1:0] QUARTER = COEF_W'(Q_QUARTER);
  localparam logic [COEF_W-1:0] WRAP    = COEF_W'(KYBER_Q - Q_QUARTER);

  logic [OFFSET_LAT-1:0] vld_sr;

  // Strobe delay line
  always_ff @(posedge clk) begin
    if (reset) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= (vld_sr << 1) | OFFSET_LAT'(ce);
    end
  end

  assign data_valid = vld_sr[OFFSET_LAT-1];

  // Only share one moves, share two passes through
  // Adding q - q/4 instead of going negative keeps c1 in [0, q)
  always_ff @(posedge clk) begin
    if (c1 >= QUARTER) begin
      y1 <= c1 - QUARTER;
    end else begin
      y1 <= c1 + WRAP;
    end
    y2 <= c2;
  end

endmodule

`default_nettype wire

//--- source/share_rescale_pow2.sv
`timescale 1ns/1ps
`default_nettype none

module share_rescale_pow2 #(
  parameter int POW_BITS = 13
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        ce,
  input  logic [kyber_pkg::COEF_W-1:0] c1,
  input  logic [kyber_pkg::COEF_W-1:0] c2,
  output logic                        data_valid,
  output logic [POW_BITS-1:0]         y1,
  output logic [POW_BITS-1:0]         y2
);

  import kyber_pkg::*;
  import mask_pkg::*;

  localparam int PROD_W = COEF_W + POW_BITS + 1;

  // floor(2^(12+POW_BITS) / q), fits in POW_BITS+1 bits
  // Estimate from it is exact or one short
  localparam logic [PROD_W-1:0] RECIP =
    PROD_W'((64'd1 << (Q_BITS + POW_BITS)) / KYBER_Q);
  localparam logic [PROD_W-1:0] Q_EXT = PROD_W'(KYBER_Q);
  // Half of the power-of-two range
  localparam logic [POW_BITS-1:0] HALF = {1'b1, {(POW_BITS-1){1'b0}}};

  logic [RESCALE_LAT-1:0] vld_sr;
  logic [PROD_W-1:0]      prod1;
  logic [PROD_W-1:0]      prod2;
  logic [COEF_W-1:0]      sh1;
  logic [COEF_W-1:0]      sh2;

  // Shift, then bump by one if the remainder is still >= q
  function automatic logic [POW_BITS-1:0] floor_fix(
    input logic [PROD_W-1:0] prod,
    input logic [COEF_W-1:0] share
  );
    logic [PROD_W-1:0] est;
    logic [PROD_W-1:0] num;
    logic [PROD_W-1:0] rem;
    est = prod >> Q_BITS;
    num = PROD_W'(share) << POW_BITS;
    rem = num - est * Q_EXT;
    if (rem >= Q_EXT) begin
      est = est + 1'b1;
    end
    return est[POW_BITS-1:0];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= (vld_sr << 1) | RESCALE_LAT'(ce);
    end
  end

  assign data_valid = vld_sr[RESCALE_LAT-1];

  ////////////////////////////////////////
  // Stage 1, reciprocal multiply
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    prod1 <= PROD_W'(c1) * RECIP;
    prod2 <= PROD_W'(c2) * RECIP;
    // Kept for the remainder check
    sh1   <= c1;
    sh2   <= c2;
  end

  ////////////////////////////////////////
  // Stage 2, floor fix and half offset
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    // Offset lands on share one only
    y1 <= floor_fix(prod1, sh1) - HALF;
    y2 <= floor_fix(prod2, sh2);
  end

endmodule

`default_nettype wire

//--- source/masked_a2b.sv
`timescale 1ns/1ps
`default_nettype none

module masked_a2b #(
  parameter int POW_BITS = 13
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       ce,
  input  logic [POW_BITS-1:0]        c1,
  input  logic [POW_BITS-1:0]        c2,
  input  logic [mask_pkg::RAND_W-1:0] prng_data,
  output logic                       data_valid,
  output logic [POW_BITS-1:0]        y1,
  output logic [POW_BITS-1:0]        y2
);

  import mask_pkg::*;

  // Carry recurrence split over the three stages
  localparam int N_ITER = POW_BITS - 1;
  localparam int N_S1   = N_ITER / 3;
  localparam int N_S2   = N_ITER / 3;
  localparam int N_S3   = N_ITER - N_S1 - N_S2;

  logic [A2B_LAT-1:0]  vld_sr;

  // Stage 1 combinational results
  logic [POW_BITS-1:0] init_t;
  logic [POW_BITS-1:0] init_omega;
  logic [POW_BITS-1:0] init_xp;

  // Pipeline state, T and omega carry the refresh randomness
  logic [POW_BITS-1:0] s1_t;
  logic [POW_BITS-1:0] s1_omega;
  logic [POW_BITS-1:0] s1_xp;
  logic [POW_BITS-1:0] s1_a;
  logic [POW_BITS-1:0] s1_r;
  logic [POW_BITS-1:0] s2_t;
  logic [POW_BITS-1:0] s2_omega;
  logic [POW_BITS-1:0] s2_xp;
  logic [POW_BITS-1:0] s2_a;
  logic [POW_BITS-1:0] s2_r;

  // Unrolled Goubin loop body, steps iterations
  // Only T changes, omega / A / r stay fixed
  function automatic logic [POW_BITS-1:0] carry_run(
    input logic [POW_BITS-1:0] t_in,
    input logic [POW_BITS-1:0] omega,
    input logic [POW_BITS-1:0] a,
    input logic [POW_BITS-1:0] r,
    input int                  steps
  );
    logic [POW_BITS-1:0] t;
    logic [POW_BITS-1:0] g;
    t = t_in;
    for (int j = 0; j < steps; j++) begin
      g = t & r;
      g = g ^ omega;
      t = t & a;
      g = g ^ t;
      t = g << 1;
    end
    return t;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= (vld_sr << 1) | A2B_LAT'(ce);
    end
  end

  assign data_valid = vld_sr[A2B_LAT-1];

  ////////////////////////////////////////
  // Stage 1, setup with fresh gamma
  ////////////////////////////////////////
  always_comb begin : a2b_init
    logic [POW_BITS-1:0] gamma;
    logic [POW_BITS-1:0] t0;
    logic [POW_BITS-1:0] xr;
    logic [POW_BITS-1:0] g;
    logic [POW_BITS-1:0] om;
    // Random word taken in the ce cycle
    gamma = prng_data[POW_BITS-1:0];
    t0    = gamma << 1;
    xr    = gamma ^ c2;
    om    = gamma & xr;
    // x' = 2*gamma ^ A
    init_xp = t0 ^ c1;
    g     = gamma ^ init_xp;
    g     = g & c2;
    om    = om ^ g;
    g     = t0 & c1;
    om    = om ^ g;
    init_omega = om;
    init_t     = carry_run(t0, om, c1, c2, N_S1);
  end

  always_ff @(posedge clk) begin
    s1_t     <= init_t;
    s1_omega <= init_omega;
    s1_xp    <= init_xp;
    s1_a     <= c1;
    s1_r     <= c2;
  end

  ////////////////////////////////////////
  // Stage 2, middle iterations
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    s2_t     <= carry_run(s1_t, s1_omega, s1_a, s1_r, N_S2);
    s2_omega <= s1_omega;
    s2_xp    <= s1_xp;
    s2_a     <= s1_a;
    s2_r     <= s1_r;
  end

  ////////////////////////////////////////
  // Stage 3, last iterations and output
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    // x' ^ T gives (A + r) ^ r
    y1 <= s2_xp ^ carry_run(s2_t, s2_omega, s2_a, s2_r, N_S3);
    // Mask r becomes the second Boolean share
    y2 <= s2_r;
  end

endmodule

`default_nettype wire

//--- source/masked_decode.sv
`timescale 1ns/1ps
`default_nettype none

module masked_decode #(
  parameter int POW_BITS = 13
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        ce,
  input  logic [kyber_pkg::COEF_W-1:0] c1,
  input  logic [kyber_pkg::COEF_W-1:0] c2,
  input  logic [mask_pkg::RAND_W-1:0]  prng_data,
  output logic                        data_valid,
  output logic                        m1,
  output logic                        m2
);

  import kyber_pkg::*;

  logic                off_valid;
  logic [COEF_W-1:0]   off_y1;
  logic [COEF_W-1:0]   off_y2;
  logic                pw_valid;
  logic [POW_BITS-1:0] pw_y1;
  logic [POW_BITS-1:0] pw_y2;
  logic                bool_valid;
  logic [POW_BITS-1:0] bool_y1;
  logic [POW_BITS-1:0] bool_y2;

  // c1 - q/4 mod q
  quarter_offset_sub off_i (
    .clk        (clk),
    .reset      (reset),
    .ce         (ce),
    .c1         (c1),
    .c2         (c2),
    .data_valid (off_valid),
    .y1         (off_y1),
    .y2         (off_y2)
  );

  // mod q to mod 2^POW_BITS, minus half range
  share_rescale_pow2 #(
    .POW_BITS (POW_BITS)
  ) rescale_i (
    .clk        (clk),
    .reset      (reset),
    .ce         (off_valid),
    .c1         (off_y1),
    .c2         (off_y2),
    .data_valid (pw_valid),
    .y1         (pw_y1),
    .y2         (pw_y2)
  );

  // Arithmetic to Boolean shares
  masked_a2b #(
    .POW_BITS (POW_BITS)
  ) a2b_i (
    .clk        (clk),
    .reset      (reset),
    .ce         (pw_valid),
    .c1         (pw_y1),
    .c2         (pw_y2),
    .prng_data  (prng_data),
    .data_valid (bool_valid),
    .y1         (bool_y1),
    .y2         (bool_y2)
  );

  ////////////////////////////////////////
  // Output bit register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      data_valid <= 1'b0;
    end else begin
      data_valid <= bool_valid;
    end
  end

  // Top bit of each share, XOR of the two is the message bit
  always_ff @(posedge clk) begin
    m1 <= bool_y1[POW_BITS-1];
    m2 <= bool_y2[POW_BITS-1];
  end

endmodule

`default_nettype wire

//--- verif/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic reset
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held over the first 10 rising edges
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- verif/masked_decode_props.sv
`timescale 1ns/1ps
`default_nettype none

module masked_decode_props (
  input logic clk,
  input logic reset,
  input logic ce,
  input logic data_valid,
  input logic m1,
  input logic m2
);

  import mask_pkg::*;

  // Valid chain cleared in reset and still low one cycle later
  a_reset_clears_valid: assert property (
    @(posedge clk) (reset || $past(reset)) |=> !data_valid
  ) else $error("data_valid high during reset or on the cycle after it");

  // Strobe comes out a fixed number of cycles later
  a_fixed_latency: assert property (
    @(posedge clk) disable iff (reset) data_valid == $past(ce, DECODE_LAT)
  ) else $error("data_valid does not match ce delayed by the decode latency");

  // Output shares must be driven whenever they are valid
  a_known_bits: assert property (
    @(posedge clk) data_valid |-> !$isunknown({m1, m2})
  ) else $error("m1 or m2 unknown while data_valid is high");

endmodule

bind masked_decode masked_decode_props props_i (
  .clk        (clk),
  .reset      (reset),
  .ce         (ce),
  .data_valid (data_valid),
  .m1         (m1),
  .m2         (m2)
);

`default_nettype wire

//--- verif/masked_decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module masked_decode_tb;

  import kyber_pkg::*;
  import mask_pkg::*;

  localparam int POW_BITS      = 13;
  localparam int MAX_ROWS      = 64;
  localparam int RESET_TIMEOUT = 40;
  localparam int DRAIN_TIMEOUT = 4 * DECODE_LAT + 20;

  logic              clk;
  logic              reset;
  logic              ce;
  logic [COEF_W-1:0] c1;
  logic [COEF_W-1:0] c2;
  logic [RAND_W-1:0] prng_data = '0;
  logic              data_valid;
  logic              m1;
  logic              m2;

  // Word 0 is the row count, then c1, c2, prng, bit per row
  logic [15:0] gold_mem [0:4*MAX_ROWS];
  int          n_rows = 0;
  int          cur_row;
  // Row tags riding along to the A2B sampling cycle
  int          rand_row_d1 = -1;
  int          rand_row_d2 = -1;

  // Scoreboard state
  int   exp_row_q[$];
  int   exp_cyc_q[$];
  int   cycle_cnt      = 0;
  int   ce_count       = 0;
  int   valid_count    = 0;
  int   decode_errors  = 0;
  int   latency_errors = 0;
  int   valid_errors   = 0;
  int   mask_errors    = 0;
  int   setup_errors   = 0;
  bit   timed_out      = 1'b0;
  logic got_bit  [0:MAX_ROWS-1];
  logic got_m1   [0:MAX_ROWS-1];
  bit   got_seen [0:MAX_ROWS-1];

  clock_gen clk_gen_i (
    .clk   (clk),
    .reset (reset)
  );

  masked_decode #(
    .POW_BITS (POW_BITS)
  ) dut_i (
    .clk        (clk),
    .reset      (reset),
    .ce         (ce),
    .c1         (c1),
    .c2         (c2),
    .prng_data  (prng_data),
    .data_valid (data_valid),
    .m1         (m1),
    .m2         (m2)
  );

  function automatic int word_index(input int row, input int col);
    return 1 + 4 * row + col;
  endfunction

  function automatic void load_golden();
    $readmemh("verif/masked_decode_golden.txt", gold_mem);
    n_rows = int'(gold_mem[0]);
    if (n_rows <= 0 || n_rows > MAX_ROWS) begin
      $display("Golden file row count %0d is out of range", n_rows);
      setup_errors++;
      n_rows = 0;
    end
    // Both shares must already be reduced mod q
    for (int i = 0; i < n_rows; i++) begin
      if (gold_mem[word_index(i, 0)] >= KYBER_Q || gold_mem[word_index(i, 1)] >= KYBER_Q) begin
        $display("Golden row %0d holds a share outside the field", i);
        setup_errors++;
      end
    end
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic issue_row(input int row);
    @(posedge clk);
    ce      <= 1'b1;
    c1      <= gold_mem[word_index(row, 0)];
    c2      <= gold_mem[word_index(row, 1)];
    cur_row <= row;
  endtask

  // Idle shares carry junk as the data regs load every cycle
  task automatic idle_cycle();
    @(posedge clk);
    ce      <= 1'b0;
    c1      <= COEF_W'($urandom);
    c2      <= COEF_W'($urandom);
    cur_row <= -1;
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (reset !== 1'b0 && waited < RESET_TIMEOUT);
    if (reset !== 1'b0) begin
      $display("Timed out after %0d cycles waiting for reset to be released", waited);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (exp_row_q.size() != 0 && waited < DRAIN_TIMEOUT);
    if (exp_row_q.size() != 0) begin
      $display("Timed out after %0d cycles with %0d results still missing",
               waited, exp_row_q.size());
      timed_out = 1'b1;
    end
  endtask

  // PRNG word must arrive 3 cycles after its ce
  always @(posedge clk) begin
    if (ce === 1'b1) begin
      rand_row_d1 <= cur_row;
    end else begin
      rand_row_d1 <= -1;
    end
    rand_row_d2 <= rand_row_d1;
    if (rand_row_d2 >= 0) begin
      prng_data <= gold_mem[word_index(rand_row_d2, 2)];
    end else begin
      prng_data <= RAND_W'($urandom);
    end
  end

  ////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////
  always @(posedge clk) begin : scoreboard
    int   row;
    int   issued;
    logic got;
    logic exp_bit;
    cycle_cnt = cycle_cnt + 1;
    if (reset) begin
      if (data_valid === 1'b1) begin
        valid_errors++;
        $display("data_valid went high while reset was asserted");
      end
    end else begin
      if (ce === 1'b1) begin
        exp_row_q.push_back(cur_row);
        exp_cyc_q.push_back(cycle_cnt);
        ce_count++;
      end
      if (data_valid === 1'b1) begin
        valid_count++;
        if (exp_row_q.size() == 0) begin
          valid_errors++;
          $display("data_valid pulsed at cycle %0d with no coefficient in flight", cycle_cnt);
        end else begin
          row     = exp_row_q.pop_front();
          issued  = exp_cyc_q.pop_front();
          got     = m1 ^ m2;
          exp_bit = gold_mem[word_index(row, 3)][0];
          if (got !== exp_bit) begin
            decode_errors++;
            $display("ERROR decode_bit row %0d: expected %0b, actual %0b", row, exp_bit, got);
          end
          if (cycle_cnt - issued != DECODE_LAT) begin
            latency_errors++;
            $display("ERROR latency row %0d: expected %0d, actual %0d",
                     row, DECODE_LAT, cycle_cnt - issued);
          end
          got_bit[row]  = got;
          got_m1[row]   = m1;
          got_seen[row] = 1'b1;
        end
      end
    end
  end

  // Same coefficient under new randomness gives the same bit
  function automatic void check_mask_independence();
    logic exp_bit;
    for (int i = 0; i < n_rows; i++) begin
      for (int j = i + 1; j < n_rows; j++) begin
        if (got_seen[i] && got_seen[j] &&
            gold_mem[word_index(i, 0)] == gold_mem[word_index(j, 0)] &&
            gold_mem[word_index(i, 1)] == gold_mem[word_index(j, 1)] &&
            gold_mem[word_index(i, 2)] != gold_mem[word_index(j, 2)]) begin
          // The repeat must decode to the bit of the first occurrence
          exp_bit = gold_mem[word_index(i, 3)][0];
          if (got_bit[j] !== exp_bit) begin
            mask_errors++;
            $display("ERROR mask_indep rows %0d/%0d: expected %0b, actual %0b",
                     i, j, exp_bit, got_bit[j]);
          end
          if (got_m1[i] !== got_m1[j]) begin
            $display("INFO rows %0d and %0d: m1 share differs under new randomness", i, j);
          end else begin
            $display("INFO rows %0d and %0d: m1 share unchanged under new randomness", i, j);
          end
        end
      end
    end
  endfunction

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin : main_seq
    int gap;
    int total;
    ce      <= 1'b0;
    c1      <= '0;
    c2      <= '0;
    cur_row <= -1;
    void'($urandom(32'hc434ea0e));
    load_golden();
    if (setup_errors == 0) begin
      wait_reset_release();
      // Back to back with one strobe per cycle
      if (!timed_out) begin
        for (int i = 0; i < n_rows; i++) begin
          issue_row(i);
        end
        idle_cycle();
        wait_drain();
      end
      // Random idle gaps of 0 to 3 cycles
      if (!timed_out) begin
        for (int i = 0; i < n_rows; i++) begin
          issue_row(i);
          gap = $urandom_range(3, 0);
          for (int g = 0; g < gap; g++) begin
            idle_cycle();
          end
        end
        idle_cycle();
        wait_drain();
      end
      if (!timed_out) begin
        // Quiet window to catch stray strobes
        for (int i = 0; i < 2 * DECODE_LAT; i++) begin
          @(posedge clk);
        end
        if (valid_count != ce_count) begin
          valid_errors++;
          $display("ERROR valid_count: expected %0d, actual %0d", ce_count, valid_count);
        end
        check_mask_independence();
      end
    end
    total = setup_errors + decode_errors + latency_errors + valid_errors + mask_errors;
    $display("Error counts: setup %0d, decode %0d, latency %0d, valid %0d, mask %0d, timeout %0d",
             setup_errors, decode_errors, latency_errors, valid_errors, mask_errors,
             int'(timed_out));
    if (total == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/masked_decode_golden.txt
// First word: row count. Then one row per coefficient, all hex
// Columns: c1  c2  prng_word  expected_bit
0024
0000 0000 3a7c 0
0680 0000 91e5 1
0340 0000 5d02 0
0341 0000 c7b9 1
09c0 0000 0e4f 1
09c1 0000 a613 1
09c2 0000 77d8 0
0919 03e8 2b6a 0
0c5a 03e8 f0c1 0
0c5b 03e8 4e97 1
0298 03e8 b35c 1
05d8 03e8 6a20 1
05db 03e8 d98e 0
0531 07d0 1f47 0
0919 07d0 8c3b 1
0000 07d0 e2a5 1
03e8 07d0 5714 0
0341 0d00 c86d 0
0342 0d00 3b09 0
0344 0d00 a4f2 1
09c1 0d00 69be 1
09c2 0d00 f5d3 1
09c5 0d00 0b78 0
0681 0680 d26c 0
0000 0680 4791 1
09c2 0680 9ce0 0
0341 0680 2a35 1
02ee 01f4 e81b 1
0a28 01f4 71c6 0
0c9d 01f4 be4a 0
0c5a 03e8 0d9f 0
05d8 03e8 7f31 1
0342 0d00 1ca4 0
0000 0680 b6e8 1
0680 0000 5a53 1
09c1 0d00 83fd 1

//--- list.f
source/kyber_pkg.sv
source/mask_pkg.sv
source/quarter_offset_sub.sv
source/share_rescale_pow2.sv
source/masked_a2b.sv
source/masked_decode.sv
verif/clock_gen.sv
verif/masked_decode_props.sv
verif/masked_decode_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert
TOP       := masked_decode_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
